// ==== hw/afifo_cfg.svh ====
/*
 * Dual-clock FIFO configuration
 * Word width, depth and synchronizer length shared by every block
 */

`ifndef AFIFO_CFG_SVH
`define AFIFO_CFG_SVH

// Data word width in bits
`define AFIFO_WIDTH 8

// Number of entries, must be a power of two for the Gray full test
`define AFIFO_DEPTH 8
`define AFIFO_PTR_BITS 3

// Flops in each pointer synchronizer
`define AFIFO_SYNC_STAGES 2

`endif

// ==== hw/afifo_pkg.sv ====
/*
 * Dual-clock FIFO types
 * Pointer, level and data types, status struct and Gray code helpers
 */

`include "afifo_cfg.svh"

package afifo_pkg;

  localparam int PTR_W = `AFIFO_PTR_BITS + 1;

  typedef logic [`AFIFO_WIDTH-1:0] data_t;
  typedef logic [`AFIFO_PTR_BITS-1:0] addr_t;
  // Top bit is the lap bit
  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W-1:0] level_t;

  // Status seen by one side of the queue
  typedef struct packed {
    level_t level;
    logic   empty;
    logic   almost_empty;
    logic   full;
    logic   almost_full;
    logic   below_lower;
    logic   above_upper;
  } fifo_status_t;

  function automatic ptr_t bin_to_gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[PTR_W-1] = gray[PTR_W-1];
    // Each binary bit folds in all Gray bits above it
    for (int i = PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== hw/gray_pointer.sv ====
/*
 * Gray pointer
 * Loadable binary counter with a registered Gray copy for crossing clocks
 */

`timescale 1ns/1ns

module gray_pointer
  import afifo_pkg::*;
(
  input  logic clock,
  input  logic resetn,
  input  logic increment,
  input  logic load,
  // Load value given in binary form
  input  ptr_t load_value,
  output ptr_t binary,
  output ptr_t gray
);

  ptr_t binary_next;

  // Wraps through both laps
  assign binary_next = ptr_t'(binary + 1'b1);

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      binary <= '0;
      gray   <= '0;
    end else if (load) begin
      binary <= load_value;
      // A load may move several Gray bits at once
      gray   <= bin_to_gray(load_value);
    end else if (increment) begin
      binary <= binary_next;
      // Gray copy registered so only one bit flips per step
      gray   <= bin_to_gray(binary_next);
    end
  end

  // Flush and access are mutually exclusive in both sides
  increment_load_exclusive : assert property (
    @(posedge clock) disable iff (!resetn)
    !(increment && load)
  ) else $error("gray_pointer: increment and load high together");

endmodule

// ==== hw/pointer_sync.sv ====
/*
 * Pointer synchronizer
 * Carries a Gray pointer into the destination clock domain
 */

`timescale 1ns/1ns
`include "afifo_cfg.svh"

module pointer_sync
  import afifo_pkg::*;
(
  input  logic clock,
  input  logic resetn,
  input  ptr_t gray_in,
  output ptr_t gray_out
);

  ptr_t stage_q [`AFIFO_SYNC_STAGES];

  // Shift chain clocked in the destination domain
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < `AFIFO_SYNC_STAGES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= gray_in;
      for (int i = 1; i < `AFIFO_SYNC_STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign gray_out = stage_q[`AFIFO_SYNC_STAGES-1];

endmodule

// ==== hw/afifo_storage.sv ====
/*
 * FIFO storage
 * Register array written on the write clock, read combinationally
 */

`timescale 1ns/1ns
`include "afifo_cfg.svh"

module afifo_storage
  import afifo_pkg::*;
(
  input  logic  write_clock,
  input  logic  mem_write_enable,
  input  addr_t mem_write_address,
  input  data_t write_data,
  input  addr_t mem_read_address,
  output data_t read_data
);

  data_t mem [`AFIFO_DEPTH];

  always_ff @(posedge write_clock) begin
    if (mem_write_enable) begin
      mem[mem_write_address] <= write_data;
    end
  end

  // Head entry always visible on the read port
  assign read_data = mem[mem_read_address];

endmodule

// ==== hw/afifo_write_side.sv ====
/*
 * FIFO write side
 * Write pointer, write-domain flags and thresholds, miss pulse on a refused write
 */

`timescale 1ns/1ns
`include "afifo_cfg.svh"

module afifo_write_side
  import afifo_pkg::*;
(
  input  logic         write_clock,
  input  logic         write_resetn,
  input  logic         write_enable,
  input  logic         write_flush,
  input  level_t       write_lower,
  input  level_t       write_upper,
  // Read pointer already in this domain
  input  ptr_t         read_gray_sync,
  output ptr_t         write_gray,
  output logic         mem_write_enable,
  output addr_t        mem_write_address,
  output fifo_status_t write_status,
  output logic         write_miss
);

  ptr_t   write_bin;
  ptr_t   read_bin;
  level_t level;
  logic   empty;
  logic   full;
  logic   do_write;

  // Read pointer back to binary for the level and the flush load
  assign read_bin = gray_to_bin(read_gray_sync);

  // Accept only when room is left and no flush is running
  assign do_write = write_enable && !full && !write_flush;

  gray_pointer write_pointer (
    .clock      (write_clock),
    .resetn     (write_resetn),
    .increment  (do_write),
    .load       (write_flush),
    .load_value (read_bin),
    .binary     (write_bin),
    .gray       (write_gray)
  );

  assign level = level_t'(write_bin - read_bin);

  // Same Gray value means both pointers on the same entry and lap
  assign empty = write_gray == read_gray_sync;
  // One lap ahead, Gray form differs only in the two top bits
  assign full = write_gray == {~read_gray_sync[`AFIFO_PTR_BITS -: 2],
                               read_gray_sync[`AFIFO_PTR_BITS-2:0]};

  always_comb begin
    write_status.level        = level;
    write_status.empty        = empty;
    write_status.almost_empty = level == level_t'(1);
    write_status.full         = full;
    write_status.almost_full  = level == level_t'(`AFIFO_DEPTH - 1);
    write_status.below_lower  = level <= write_lower;
    write_status.above_upper  = level >= write_upper;
  end

  // Storage port, address drops the lap bit
  assign mem_write_enable  = do_write;
  assign mem_write_address = write_bin[`AFIFO_PTR_BITS-1:0];

  // One-cycle pulse for a write refused because the queue is full
  always_ff @(posedge write_clock or negedge write_resetn) begin
    if (!write_resetn) begin
      write_miss <= 1'b0;
    end else begin
      write_miss <= write_enable && full && !write_flush;
    end
  end

  // Read pointer can only trail the write pointer by up to one lap
  level_within_depth : assert property (
    @(posedge write_clock) disable iff (!write_resetn)
    level <= level_t'(`AFIFO_DEPTH)
  ) else $error("afifo_write_side: level above depth");

  // Binary level at depth must agree with the Gray full test
  no_store_when_full : assert property (
    @(posedge write_clock) disable iff (!write_resetn)
    (level == level_t'(`AFIFO_DEPTH)) |-> !mem_write_enable
  ) else $error("afifo_write_side: storage written while full");

endmodule

// ==== hw/afifo_read_side.sv ====
/*
 * FIFO read side
 * Read pointer, read-domain flags and thresholds, error pulse on a refused read
 */

`timescale 1ns/1ns
`include "afifo_cfg.svh"

module afifo_read_side
  import afifo_pkg::*;
(
  input  logic         read_clock,
  input  logic         read_resetn,
  input  logic         read_enable,
  input  logic         read_flush,
  input  level_t       read_lower,
  input  level_t       read_upper,
  // Write pointer already in this domain
  input  ptr_t         write_gray_sync,
  output ptr_t         read_gray,
  output addr_t        mem_read_address,
  output fifo_status_t read_status,
  output logic         read_error
);

  ptr_t   read_bin;
  ptr_t   write_bin;
  level_t level;
  logic   empty;
  logic   full;
  logic   do_read;

  // Write pointer back to binary for the level and the flush load
  assign write_bin = gray_to_bin(write_gray_sync);

  // Accept only when data is visible and no flush is running
  assign do_read = read_enable && !empty && !read_flush;

  gray_pointer read_pointer (
    .clock      (read_clock),
    .resetn     (read_resetn),
    .increment  (do_read),
    .load       (read_flush),
    .load_value (write_bin),
    .binary     (read_bin),
    .gray       (read_gray)
  );

  assign level = level_t'(write_bin - read_bin);

  assign empty = write_gray_sync == read_gray;
  // Writer one lap ahead
  assign full = write_gray_sync == {~read_gray[`AFIFO_PTR_BITS -: 2],
                                    read_gray[`AFIFO_PTR_BITS-2:0]};

  always_comb begin
    read_status.level        = level;
    read_status.empty        = empty;
    read_status.almost_empty = level == level_t'(1);
    read_status.full         = full;
    read_status.almost_full  = level == level_t'(`AFIFO_DEPTH - 1);
    read_status.below_lower  = level <= read_lower;
    read_status.above_upper  = level >= read_upper;
  end

  // Head entry address, storage returns it without a clock
  assign mem_read_address = read_bin[`AFIFO_PTR_BITS-1:0];

  // One-cycle pulse for a read refused because the queue is empty
  always_ff @(posedge read_clock or negedge read_resetn) begin
    if (!read_resetn) begin
      read_error <= 1'b0;
    end else begin
      read_error <= read_enable && empty && !read_flush;
    end
  end

  // Zero binary level must hold the pointer until new data arrives
  no_advance_when_empty : assert property (
    @(posedge read_clock) disable iff (!read_resetn)
    (level == '0 && !read_flush) |=> $stable(read_bin)
  ) else $error("afifo_read_side: read pointer moved while empty");

  // Synchronized writer never gets more than one lap ahead
  level_within_depth : assert property (
    @(posedge read_clock) disable iff (!read_resetn)
    level <= level_t'(`AFIFO_DEPTH)
  ) else $error("afifo_read_side: level above depth");

endmodule

// ==== hw/afifo_top.sv ====
/*
 * Dual-clock FIFO
 * Write side, storage and read side with Gray pointer synchronizers between domains
 */

`timescale 1ns/1ns

module afifo_top
  import afifo_pkg::*;
(
  // Write domain
  input  logic         write_clock,
  input  logic         write_resetn,
  input  logic         write_enable,
  input  data_t        write_data,
  input  logic         write_flush,
  input  level_t       write_lower,
  input  level_t       write_upper,
  output fifo_status_t write_status,
  output logic         write_miss,
  // Read domain
  input  logic         read_clock,
  input  logic         read_resetn,
  input  logic         read_enable,
  input  logic         read_flush,
  input  level_t       read_lower,
  input  level_t       read_upper,
  output data_t        read_data,
  output fifo_status_t read_status,
  output logic         read_error
);

  ptr_t  write_gray;
  ptr_t  write_gray_sync;
  ptr_t  read_gray;
  ptr_t  read_gray_sync;
  logic  mem_write_enable;
  addr_t mem_write_address;
  addr_t mem_read_address;

  afifo_write_side write_side (
    .write_clock       (write_clock),
    .write_resetn      (write_resetn),
    .write_enable      (write_enable),
    .write_flush       (write_flush),
    .write_lower       (write_lower),
    .write_upper       (write_upper),
    .read_gray_sync    (read_gray_sync),
    .write_gray        (write_gray),
    .mem_write_enable  (mem_write_enable),
    .mem_write_address (mem_write_address),
    .write_status      (write_status),
    .write_miss        (write_miss)
  );

  afifo_storage storage (
    .write_clock       (write_clock),
    .mem_write_enable  (mem_write_enable),
    .mem_write_address (mem_write_address),
    .write_data        (write_data),
    .mem_read_address  (mem_read_address),
    .read_data         (read_data)
  );

  afifo_read_side read_side (
    .read_clock       (read_clock),
    .read_resetn      (read_resetn),
    .read_enable      (read_enable),
    .read_flush       (read_flush),
    .read_lower       (read_lower),
    .read_upper       (read_upper),
    .write_gray_sync  (write_gray_sync),
    .read_gray        (read_gray),
    .mem_read_address (mem_read_address),
    .read_status      (read_status),
    .read_error       (read_error)
  );

  // Write pointer into the read domain
  pointer_sync write_to_read_sync (
    .clock    (read_clock),
    .resetn   (read_resetn),
    .gray_in  (write_gray),
    .gray_out (write_gray_sync)
  );

  // Read pointer back into the write domain
  pointer_sync read_to_write_sync (
    .clock    (write_clock),
    .resetn   (write_resetn),
    .gray_in  (read_gray),
    .gray_out (read_gray_sync)
  );

endmodule

// ==== tests/afifo_tb.sv ====
/*
 * Dual-clock FIFO testbench
 * Queue model, reference status function and read data comparison
 */

`timescale 1ns/1ns
`include "afifo_cfg.svh"

module afifo_tb
  import afifo_pkg::*;
  ();

  logic         read_clock = 1'b0;
  logic         write_clock = 1'b0;
  logic         read_resetn;
  logic         write_resetn;
  logic         write_enable;
  data_t        write_data;
  logic         write_flush;
  level_t       write_lower;
  level_t       write_upper;
  fifo_status_t write_status;
  logic         write_miss;
  logic         read_enable;
  logic         read_flush;
  level_t       read_lower;
  level_t       read_upper;
  data_t        read_data;
  fifo_status_t read_status;
  logic         read_error;

  int          errors;
  data_t       model_q[$];
  logic [31:0] lcg_state;

  // Unrelated periods so the phase between the two domains drifts
  always #5 read_clock = ~read_clock;
  always #7 write_clock = ~write_clock;

  afifo_top uut (
    .write_clock  (write_clock),
    .write_resetn (write_resetn),
    .write_enable (write_enable),
    .write_data   (write_data),
    .write_flush  (write_flush),
    .write_lower  (write_lower),
    .write_upper  (write_upper),
    .write_status (write_status),
    .write_miss   (write_miss),
    .read_clock   (read_clock),
    .read_resetn  (read_resetn),
    .read_enable  (read_enable),
    .read_flush   (read_flush),
    .read_lower   (read_lower),
    .read_upper   (read_upper),
    .read_data    (read_data),
    .read_status  (read_status),
    .read_error   (read_error)
  );

  function automatic logic [31:0] next_rand(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Status that a side should show when it sees count entries
  function automatic fifo_status_t expected_status(input int count, input level_t lower,
                                                   input level_t upper);
    fifo_status_t s;
    s.level        = level_t'(count);
    s.empty        = count == 0;
    s.almost_empty = count == 1;
    s.full         = count == `AFIFO_DEPTH;
    s.almost_full  = count == `AFIFO_DEPTH - 1;
    s.below_lower  = count <= int'(lower);
    s.above_upper  = count >= int'(upper);
    return s;
  endfunction

  task automatic compare_status(input string name, input fifo_status_t got,
                                input fifo_status_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_both();
    compare_status("write_status", write_status,
                   expected_status(model_q.size(), write_lower, write_upper));
    compare_status("read_status", read_status,
                   expected_status(model_q.size(), read_lower, read_upper));
  endtask

  // Wait until both sides see the model count, then check both statuses
  task automatic settle();
    int cycles;
    cycles = 0;
    @(negedge read_clock);
    while ((int'(write_status.level) != model_q.size() ||
            int'(read_status.level) != model_q.size()) && cycles < 40) begin
      @(negedge read_clock);
      cycles++;
    end
    if (int'(write_status.level) != model_q.size() ||
        int'(read_status.level) != model_q.size()) begin
      $display("Timeout: levels did not settle at model count %0d", model_q.size());
      errors++;
    end
    check_both();
  endtask

  // One write request, the model decides if it is accepted
  task automatic write_word(input data_t d);
    logic expect_miss;
    @(negedge write_clock);
    expect_miss = model_q.size() >= `AFIFO_DEPTH;
    write_enable = 1'b1;
    write_data = d;
    if (!expect_miss) begin
      model_q.push_back(d);
    end
    @(negedge write_clock);
    write_enable = 1'b0;
    compare_bit("write_miss", write_miss, expect_miss);
    compare_status("write_status", write_status,
                   expected_status(model_q.size(), write_lower, write_upper));
  endtask

  task automatic write_random();
    lcg_state = next_rand(lcg_state);
    write_word(lcg_state[31:24]);
  endtask

  // One read request, data is checked by the compare process
  task automatic read_word();
    logic expect_error;
    @(negedge read_clock);
    expect_error = model_q.size() == 0;
    read_enable = 1'b1;
    @(negedge read_clock);
    read_enable = 1'b0;
    compare_bit("read_error", read_error, expect_error);
    compare_status("read_status", read_status,
                   expected_status(model_q.size(), read_lower, read_upper));
  endtask

  task automatic write_then_drain(input int n);
    repeat (n) begin
      write_random();
      settle();
    end
    repeat (n) begin
      read_word();
      settle();
    end
  endtask

  // Head of the model against read_data on every accepted read
  always @(posedge read_clock) begin
    if (read_resetn && read_enable && !read_flush && model_q.size() > 0) begin
      if (read_data !== model_q[0]) begin
        $display("Mismatch read_data: got %h expected %h", read_data, model_q[0]);
        errors++;
      end
      void'(model_q.pop_front());
    end
  end

  initial begin
    errors = 0;
    lcg_state = 32'h8ab87d01;
    read_resetn = 1'b0;
    write_resetn = 1'b0;
    write_enable = 1'b0;
    write_data = '0;
    write_flush = 1'b0;
    write_lower = level_t'(1);
    write_upper = level_t'(7);
    read_enable = 1'b0;
    read_flush = 1'b0;
    read_lower = level_t'(1);
    read_upper = level_t'(7);
    repeat (16) @(posedge read_clock);
    @(negedge read_clock);
    read_resetn = 1'b1;
    write_resetn = 1'b1;

    // Idle after reset
    repeat (4) begin
      @(negedge read_clock);
      check_both();
      compare_bit("write_miss", write_miss, 1'b0);
      compare_bit("read_error", read_error, 1'b0);
    end

    write_then_drain(6);

    // Fill to depth, then one refused write
    repeat (`AFIFO_DEPTH) begin
      write_random();
      settle();
    end
    compare_bit("write_status.full", write_status.full, 1'b1);
    write_random();
    @(negedge write_clock);
    compare_bit("write_miss", write_miss, 1'b0);
    compare_status("write_status", write_status,
                   expected_status(model_q.size(), write_lower, write_upper));
    settle();
    compare_bit("read_status.full", read_status.full, 1'b1);
    repeat (`AFIFO_DEPTH) begin
      read_word();
      settle();
    end

    // Read from an empty queue
    read_word();
    @(negedge read_clock);
    compare_bit("read_error", read_error, 1'b0);
    settle();

    // Threshold flags on both sides
    @(negedge write_clock);
    write_lower = level_t'(2);
    write_upper = level_t'(5);
    @(negedge read_clock);
    read_lower = level_t'(2);
    read_upper = level_t'(5);
    write_then_drain(6);

    // Write flush drops all stored entries
    repeat (5) begin
      write_random();
    end
    settle();
    @(negedge write_clock);
    write_flush = 1'b1;
    model_q.delete();
    @(negedge write_clock);
    write_flush = 1'b0;
    settle();
    write_then_drain(2);

    // Read flush does the same from the read domain
    repeat (3) begin
      write_random();
    end
    settle();
    @(negedge read_clock);
    read_flush = 1'b1;
    model_q.delete();
    @(negedge read_clock);
    read_flush = 1'b0;
    settle();
    write_then_drain(2);

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/afifo_pkg.sv
hw/gray_pointer.sv
hw/pointer_sync.sv
hw/afifo_storage.sv
hw/afifo_write_side.sv
hw/afifo_read_side.sv
hw/afifo_top.sv
tests/afifo_tb.sv

// ==== Bender.yml ====
package:
  name: afifo

sources:
  - include_dirs:
      - hw
    files:
      - hw/afifo_pkg.sv
      - hw/gray_pointer.sv
      - hw/pointer_sync.sv
      - hw/afifo_storage.sv
      - hw/afifo_write_side.sv
      - hw/afifo_read_side.sv
      - hw/afifo_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/afifo_tb.sv
